//--- Bender.yml
package:
  name: mem_stage

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/core_mem_pkg.sv
      - rtl/core_pipe_pkg.sv
      - rtl/mem_decode.sv
      - rtl/mem_execute.sv
      - rtl/mem_result.sv
      - rtl/mem_stage_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/mem_stage_sva.sv
      - test/tb_mem_stage.sv

//--- flist.f
+incdir+rtl
rtl/core_mem_pkg.sv
rtl/core_pipe_pkg.sv
rtl/mem_decode.sv
rtl/mem_execute.sv
rtl/mem_result.sv
rtl/mem_stage_top.sv
test/mem_stage_sva.sv
test/tb_mem_stage.sv

//--- rtl/core_defines.svh
// -------------------------------------------------------------------------
// global widths and reset constants of the core memory stage
// include in packages and modules that size data or load the CSR window
// -------------------------------------------------------------------------
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// data and address width
`define CORE_XLEN 32

// register file index width
`define CORE_REG_W 5

// -------------------------------------------------------------------------
// non-cacheable window after reset
// an address is uncached when (addr & mask) == base
// -------------------------------------------------------------------------

// top 256 MiB region at 0xF000_0000 holds the peripherals
`define CORE_NC_BASE_RST 32'hF000_0000

// compare only the top nibble
`define CORE_NC_MASK_RST 32'hF000_0000

`endif

//--- rtl/core_mem_pkg.sv
// -------------------------------------------------------------------------
// memory-side types: access opcodes, sizes, the L1D request/response pair
// and the decoded access handed from decode to execute and result
// -------------------------------------------------------------------------
`default_nettype none

`include "core_defines.svh"

package core_mem_pkg;

	// access opcode
	typedef enum logic [1:0] {
		MEM_NONE  = 2'd0,
		MEM_LOAD  = 2'd1,
		MEM_STORE = 2'd2
	} mem_op_e;

	// access size, same code as funct3[1:0]
	typedef enum logic [1:0] {
		SIZE_BYTE = 2'd0,
		SIZE_HALF = 2'd1,
		SIZE_WORD = 2'd2
	} mem_size_e;

	// request towards the data cache, paired with l1d_req_valid
	typedef struct packed {
		mem_op_e               op;
		mem_size_e             size;
		logic                  uncached;
		logic [`CORE_XLEN-1:0] addr;
		logic [`CORE_XLEN-1:0] wdata;
	} l1d_req_t;

	// ready completes the access, rdata is the full aligned word
	typedef struct packed {
		logic                  ready;
		logic [`CORE_XLEN-1:0] rdata;
	} l1d_rsp_t;

	// decoded access
	typedef struct packed {
		mem_op_e               op;
		mem_size_e             size;
		logic                  uncached;
		logic [1:0]            lane;
		logic                  misalign;
		logic [`CORE_XLEN-1:0] addr;
	} acc_t;

endpackage

`default_nettype wire

//--- rtl/core_pipe_pkg.sv
// -------------------------------------------------------------------------
// pipeline-side types of the memory stage: the instruction coming from
// execute, the writeback entry and the hazard forward
// -------------------------------------------------------------------------
`default_nettype none

`include "core_defines.svh"

package core_pipe_pkg;

	// writeback value source
	typedef enum logic [1:0] {
		WB_ALU = 2'd0,
		WB_MEM = 2'd1,
		WB_PC4 = 2'd2,
		WB_IMM = 2'd3
	} wb_src_e;

	// load extension, encoded as the load funct3
	typedef enum logic [2:0] {
		LD_LB  = 3'd0,
		LD_LH  = 3'd1,
		LD_LW  = 3'd2,
		LD_LBU = 3'd4,
		LD_LHU = 3'd5
	} ld_ext_e;

	// instruction entering the stage
	// alu_result doubles as the access address
	typedef struct packed {
		logic                    valid;
		core_mem_pkg::mem_op_e   mem_op;
		core_mem_pkg::mem_size_e size;
		ld_ext_e                 ld_ext;
		wb_src_e                 wb_src;
		logic [`CORE_REG_W-1:0]  rd;
		logic                    we;
		logic [`CORE_XLEN-1:0]   alu_result;
		logic [`CORE_XLEN-1:0]   sx_imm;
		logic [`CORE_XLEN-1:0]   pc_4;
		logic [`CORE_XLEN-1:0]   store_data;
	} mem_in_t;

	// stage register towards writeback
	typedef struct packed {
		logic                   valid;
		logic [`CORE_REG_W-1:0] rd;
		logic                   we;
		logic                   misalign;
		logic [`CORE_XLEN-1:0]  value;
	} wb_t;

	// forward to the hazard unit for the execute bypass
	typedef struct packed {
		logic [`CORE_REG_W-1:0] rd;
		logic                   we;
		logic [`CORE_XLEN-1:0]  alu_result;
	} haz_fwd_t;

endpackage

`default_nettype wire

//--- rtl/mem_decode.sv
// -------------------------------------------------------------------------
// memory stage decode: access class, byte lane, alignment check and the
// non-cacheable window compare; also drives the hazard forward
// -------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "core_defines.svh"

module mem_decode (
	input  core_pipe_pkg::mem_in_t  mem_in,
	input  logic [`CORE_XLEN-1:0]   csr_nc_base,
	input  logic [`CORE_XLEN-1:0]   csr_nc_mask,
	output core_mem_pkg::acc_t      acc,
	output core_pipe_pkg::haz_fwd_t haz_fwd
);
	import core_mem_pkg::*;

	logic [1:0] lane;
	logic       bad_align;

	assign lane = mem_in.alu_result[1:0];

	// halfword needs an even address, word needs lane 0
	always_comb begin
		case (mem_in.size)
			SIZE_HALF: bad_align = lane[0];
			SIZE_WORD: bad_align = (lane != 2'd0);
			default:   bad_align = 1'b0;
		endcase
	end

	always_comb begin
		acc.op       = mem_in.mem_op;
		acc.size     = mem_in.size;
		acc.addr     = mem_in.alu_result;
		acc.lane     = lane;
		// non-memory ops carry a don't-care size
		acc.misalign = (mem_in.mem_op != MEM_NONE) && bad_align;
		acc.uncached = (mem_in.alu_result & csr_nc_mask) == csr_nc_base;
	end

	// hazard forward
	// only a valid instruction may claim a write
	always_comb begin
		haz_fwd.rd         = mem_in.rd;
		haz_fwd.we         = mem_in.valid && mem_in.we;
		haz_fwd.alu_result = mem_in.alu_result;
	end

endmodule

`default_nettype wire

//--- rtl/mem_execute.sv
// -------------------------------------------------------------------------
// memory stage access: store data bypass and lane replication, the L1D
// request with its hold under back-pressure, stall and the done pulse
// -------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "core_defines.svh"

module mem_execute (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   valid,
	input  core_mem_pkg::acc_t     acc,
	input  logic [`CORE_XLEN-1:0]  store_data,
	input  logic                   bp_sel,
	input  logic [`CORE_XLEN-1:0]  bp_data,
	input  logic                   kill,
	output core_mem_pkg::l1d_req_t l1d_req,
	output logic                   l1d_req_valid,
	input  core_mem_pkg::l1d_rsp_t l1d_rsp,
	output logic                   stall,
	output logic                   done,
	output logic [`CORE_XLEN-1:0]  load_word
);
	import core_mem_pkg::*;

	typedef enum logic {
		IDLE = 1'b0,
		WAIT = 1'b1
	} state_e;

	state_e                state;
	state_e                state_nxt;
	logic                  is_mem;
	logic [`CORE_XLEN-1:0] st_data;
	l1d_req_t              req_new;
	l1d_req_t              req_held;

	// aligned load or store that goes to the cache
	assign is_mem  = valid && (acc.op != MEM_NONE) && !acc.misalign;
	assign st_data = bp_sel ? bp_data : store_data;

	always_comb begin
		req_new.op       = acc.op;
		req_new.size     = acc.size;
		req_new.uncached = acc.uncached;
		req_new.addr     = acc.addr;
		// cache picks the lanes by addr and size
		case (acc.size)
			SIZE_BYTE: req_new.wdata = {4{st_data[7:0]}};
			SIZE_HALF: req_new.wdata = {2{st_data[15:0]}};
			default:   req_new.wdata = st_data;
		endcase
	end

	// ---------------------------------------------------------------------
	// request and handshake
	// ---------------------------------------------------------------------
	assign l1d_req_valid = is_mem && !kill;
	assign l1d_req       = (state == WAIT) ? req_held : req_new;
	assign stall         = l1d_req_valid && !l1d_rsp.ready;
	assign done          = valid && !kill && (!is_mem || l1d_rsp.ready);
	// rdata only means something in the ready cycle, with done
	assign load_word     = l1d_rsp.rdata;

	assign state_nxt = stall ? WAIT : IDLE;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// freeze the first-cycle request, bypass data may move meanwhile
	always_ff @(posedge clk) begin
		if (state == IDLE && stall) begin
			req_held <= req_new;
		end
	end

endmodule

`default_nettype wire

//--- rtl/mem_result.sv
// -------------------------------------------------------------------------
// memory stage result: load lane select and extension, writeback value
// select and the stage register towards writeback
// wb.valid pulses once per completed instruction
// -------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "core_defines.svh"

module mem_result (
	input  logic                   clk,
	input  logic                   rst,
	input  core_pipe_pkg::mem_in_t mem_in,
	input  core_mem_pkg::acc_t     acc,
	input  logic                   done,
	input  logic [`CORE_XLEN-1:0]  load_word,
	input  logic                   kill,
	output core_pipe_pkg::wb_t     wb
);
	import core_pipe_pkg::*;

	logic [`CORE_XLEN-1:0] ld_shift;
	logic [`CORE_XLEN-1:0] ld_val;
	logic [`CORE_XLEN-1:0] wb_val;

	// move the addressed lane down to bit 0
	assign ld_shift = load_word >> {acc.lane, 3'b000};

	always_comb begin
		case (mem_in.ld_ext)
			LD_LB:   ld_val = {{24{ld_shift[7]}}, ld_shift[7:0]};
			LD_LH:   ld_val = {{16{ld_shift[15]}}, ld_shift[15:0]};
			LD_LBU:  ld_val = {24'd0, ld_shift[7:0]};
			LD_LHU:  ld_val = {16'd0, ld_shift[15:0]};
			default: ld_val = ld_shift;
		endcase
	end

	always_comb begin
		case (mem_in.wb_src)
			WB_MEM:  wb_val = ld_val;
			WB_PC4:  wb_val = mem_in.pc_4;
			WB_IMM:  wb_val = mem_in.sx_imm;
			default: wb_val = mem_in.alu_result;
		endcase
	end

	// ---------------------------------------------------------------------
	// stage register
	// ---------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (done) begin
			wb.rd       <= mem_in.rd;
			wb.misalign <= acc.misalign;
			wb.value    <= wb_val;
		end
		// kill wins over a completing item
		if (rst || kill) begin
			wb.valid <= 1'b0;
			wb.we    <= 1'b0;
		end else begin
			wb.valid <= done;
			if (done) begin
				// faulting access never writes the register file
				wb.we <= mem_in.we && !acc.misalign;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/mem_stage_top.sv
// -------------------------------------------------------------------------
// memory stage of the RV32 pipeline: decode, access and result, with the
// sampled non-cacheable window; a new CSR window applies one cycle later
// -------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "core_defines.svh"

module mem_stage_top (
	input  logic                    clk,
	input  logic                    rst,
	input  core_pipe_pkg::mem_in_t  mem_in,
	input  logic                    kill,
	input  logic [`CORE_XLEN-1:0]   csr_nc_base,
	input  logic [`CORE_XLEN-1:0]   csr_nc_mask,
	input  logic                    bp_sel,
	input  logic [`CORE_XLEN-1:0]   bp_data,
	output core_mem_pkg::l1d_req_t  l1d_req,
	output logic                    l1d_req_valid,
	input  core_mem_pkg::l1d_rsp_t  l1d_rsp,
	output logic                    stall,
	output core_pipe_pkg::haz_fwd_t haz_fwd,
	output core_pipe_pkg::wb_t      wb
);
	import core_mem_pkg::*;

	logic [`CORE_XLEN-1:0] nc_base_q;
	logic [`CORE_XLEN-1:0] nc_mask_q;
	acc_t                  acc;
	logic                  done;
	logic [`CORE_XLEN-1:0] load_word;

	// local copy of the window, reset to the boot map
	always_ff @(posedge clk) begin
		if (rst) begin
			nc_base_q <= `CORE_NC_BASE_RST;
			nc_mask_q <= `CORE_NC_MASK_RST;
		end else begin
			nc_base_q <= csr_nc_base;
			nc_mask_q <= csr_nc_mask;
		end
	end

	mem_decode u_decode (
		.mem_in      (mem_in),
		.csr_nc_base (nc_base_q),
		.csr_nc_mask (nc_mask_q),
		.acc         (acc),
		.haz_fwd     (haz_fwd)
	);

	mem_execute u_execute (
		.clk           (clk),
		.rst           (rst),
		.valid         (mem_in.valid),
		.acc           (acc),
		.store_data    (mem_in.store_data),
		.bp_sel        (bp_sel),
		.bp_data       (bp_data),
		.kill          (kill),
		.l1d_req       (l1d_req),
		.l1d_req_valid (l1d_req_valid),
		.l1d_rsp       (l1d_rsp),
		.stall         (stall),
		.done          (done),
		.load_word     (load_word)
	);

	mem_result u_result (
		.clk       (clk),
		.rst       (rst),
		.mem_in    (mem_in),
		.acc       (acc),
		.done      (done),
		.load_word (load_word),
		.kill      (kill),
		.wb        (wb)
	);

endmodule

`default_nettype wire

//--- test/mem_stage_sva.sv
// ---------------------------------------------------------------------------
// assertions on the L1D handshake, stall and the state after reset
// bound into the memory stage top level by the testbench
// ---------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module mem_stage_sva (
	input logic                   clk,
	input logic                   rst,
	input core_pipe_pkg::mem_in_t mem_in,
	input logic                   kill,
	input core_mem_pkg::l1d_req_t l1d_req,
	input logic                   l1d_req_valid,
	input core_mem_pkg::l1d_rsp_t l1d_rsp,
	input logic                   stall,
	input core_pipe_pkg::wb_t     wb
);
	import core_mem_pkg::*;

	// count of assertion failures
	int   fail_cnt = 0;
	logic bad_align;
	logic mem_access;

	// halfword on an odd address or word off lane 0
	assign bad_align = (mem_in.size == SIZE_HALF && mem_in.alu_result[0]) ||
		(mem_in.size == SIZE_WORD && mem_in.alu_result[1:0] != 2'd0);

	// valid aligned load or store that is not withdrawn
	assign mem_access = mem_in.valid && !kill && (mem_in.mem_op != MEM_NONE) && !bad_align;

	// request held until the cache takes it or kill withdraws it
	a_req_stable: assert property (@(posedge clk) disable iff (rst)
		l1d_req_valid && !l1d_rsp.ready |=> kill || (l1d_req_valid && $stable(l1d_req)))
	else begin
		$error("L1D request dropped or changed before ready");
		fail_cnt++;
	end

	a_stall: assert property (@(posedge clk) disable iff (rst)
		stall == (mem_access && !l1d_rsp.ready))
	else begin
		$error("stall does not match a waiting memory access");
		fail_cnt++;
	end

	// first cycle out of reset is quiet
	a_reset_idle: assert property (@(posedge clk)
		$fell(rst) |-> !l1d_req_valid && !stall && !wb.valid)
	else begin
		$error("request, stall or writeback active right after reset");
		fail_cnt++;
	end

endmodule

`default_nettype wire

//--- test/tb_mem_stage.sv
// ---------------------------------------------------------------------------
// drives a seeded random instruction stream into the memory stage, answers
// L1D requests from a model with random latency and predicts every
// writeback with a queue model
// ---------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "core_defines.svh"

module tb_mem_stage;
	import core_mem_pkg::*;
	import core_pipe_pkg::*;

	localparam int WAIT_LIMIT = 200;
	localparam int N_PHASES   = 4;
	localparam int N_INSTR    = 150;

	logic                  clk;
	logic                  rst;
	mem_in_t               mem_in;
	logic                  kill;
	logic [`CORE_XLEN-1:0] csr_nc_base;
	logic [`CORE_XLEN-1:0] csr_nc_mask;
	logic                  bp_sel;
	logic [`CORE_XLEN-1:0] bp_data;
	l1d_req_t              l1d_req;
	logic                  l1d_req_valid;
	l1d_rsp_t              l1d_rsp;
	logic                  stall;
	haz_fwd_t              haz_fwd;
	wb_t                   wb;

	// cache contents and the reference copy of memory
	logic [31:0] cache_mem [256];
	logic [31:0] ref_mem [256];
	logic [1:0]  wait_cnt;
	wb_t         exp_q [$];
	logic        kill_q;
	// request still waiting for ready at the last check
	logic        req_pend;

	mem_stage_top u_mem_stage_top (
		.clk           (clk),
		.rst           (rst),
		.mem_in        (mem_in),
		.kill          (kill),
		.csr_nc_base   (csr_nc_base),
		.csr_nc_mask   (csr_nc_mask),
		.bp_sel        (bp_sel),
		.bp_data       (bp_data),
		.l1d_req       (l1d_req),
		.l1d_req_valid (l1d_req_valid),
		.l1d_rsp       (l1d_rsp),
		.stall         (stall),
		.haz_fwd       (haz_fwd),
		.wb            (wb)
	);

	bind mem_stage_top mem_stage_sva u_mem_stage_sva (
		.clk           (clk),
		.rst           (rst),
		.mem_in        (mem_in),
		.kill          (kill),
		.l1d_req       (l1d_req),
		.l1d_req_valid (l1d_req_valid),
		.l1d_rsp       (l1d_rsp),
		.stall         (stall),
		.wb            (wb)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ---------------------------------------------------------------------------
	// helpers
	// ---------------------------------------------------------------------------
	task automatic stop_run();
		$display("TB FAILED");
		$fatal(1, "run stopped at %0t", $time);
	endtask

	task automatic compare(input string name, input logic [31:0] act,
			input logic [31:0] exp_val);
		if (act !== exp_val) begin
			$display("** Error: %s = 0x%h, expected 0x%h", name, act, exp_val);
			stop_run();
		end
	endtask

	// start pattern that differs for every word address
	function automatic logic [31:0] fill_word(input int idx);
		logic [7:0] a;
		a = idx[7:0];
		return {a ^ 8'hA5, ~a, a + 8'h3C, a};
	endfunction

	function automatic logic misaligned(input mem_size_e size, input logic [1:0] lane);
		return (size == SIZE_HALF && lane[0]) || (size == SIZE_WORD && lane != 2'd0);
	endfunction

	// bytes touched by an access
	function automatic logic [31:0] lane_mask(input mem_size_e size, input logic [1:0] lane);
		case (size)
			SIZE_BYTE: return 32'h0000_00FF << (8 * lane);
			SIZE_HALF: return 32'h0000_FFFF << (8 * lane);
			default:   return 32'hFFFF_FFFF;
		endcase
	endfunction

	function automatic logic [31:0] load_value(input logic [31:0] word, input logic [1:0] lane,
			input ld_ext_e ext);
		logic [31:0] s;
		s = word >> (8 * lane);
		case (ext)
			LD_LB:   return 32'($signed(s[7:0]));
			LD_LH:   return 32'($signed(s[15:0]));
			LD_LBU:  return 32'(s[7:0]);
			LD_LHU:  return 32'(s[15:0]);
			default: return s;
		endcase
	endfunction

	task automatic make_instr();
		int          kind;
		int          pick;
		logic [31:0] addr;
		kind = $urandom_range(0, 7);
		pick = $urandom_range(0, 4);
		// half the addresses land in the uncached window
		if ($urandom_range(0, 1) == 1) begin
			addr = csr_nc_base | ($urandom() & ~csr_nc_mask);
		end else begin
			addr = $urandom();
		end
		mem_in.valid      = 1'b1;
		mem_in.rd         = 5'($urandom());
		mem_in.we         = 1'($urandom());
		mem_in.sx_imm     = $urandom();
		mem_in.pc_4       = $urandom();
		mem_in.store_data = $urandom();
		mem_in.mem_op     = MEM_NONE;
		mem_in.size       = SIZE_WORD;
		mem_in.ld_ext     = LD_LW;
		mem_in.wb_src     = (pick < 2) ? WB_ALU : (pick < 4) ? WB_PC4 : WB_IMM;
		if (kind >= 3 && kind <= 5) begin
			mem_in.mem_op = MEM_LOAD;
			mem_in.wb_src = WB_MEM;
			case (pick)
				0:       mem_in.ld_ext = LD_LB;
				1:       mem_in.ld_ext = LD_LH;
				2:       mem_in.ld_ext = LD_LW;
				3:       mem_in.ld_ext = LD_LBU;
				default: mem_in.ld_ext = LD_LHU;
			endcase
			// size is funct3[1:0]
			mem_in.size = mem_size_e'(mem_in.ld_ext[1:0]);
		end else if (kind >= 6) begin
			mem_in.mem_op = MEM_STORE;
			mem_in.we     = 1'b0;
			mem_in.size   = mem_size_e'($urandom_range(0, 2));
		end
		// most accesses aligned and the rest keep random low bits
		if ($urandom_range(0, 3) != 0) begin
			if (mem_in.size == SIZE_HALF) addr[0] = 1'b0;
			if (mem_in.size == SIZE_WORD) addr[1:0] = 2'b00;
		end
		mem_in.alu_result = addr;
		bp_sel  = ($urandom_range(0, 3) == 0);
		bp_data = $urandom();
		kill    = ($urandom_range(0, 15) == 0);
	endtask

	// ---------------------------------------------------------------------------
	// cache model answering each request after 0 to 3 cycles
	// ---------------------------------------------------------------------------
	assign l1d_rsp = {l1d_req_valid && (wait_cnt == 2'd0), cache_mem[l1d_req.addr[9:2]]};

	always begin : cache_model
		logic        seen_valid;
		logic        seen_ready;
		l1d_req_t    seen_req;
		logic [1:0]  next_wait;
		logic [31:0] m;
		@(negedge clk);
		seen_valid = l1d_req_valid;
		seen_ready = l1d_rsp.ready;
		seen_req   = l1d_req;
		next_wait  = 2'($urandom_range(0, 3));
		@(posedge clk);
		#1;
		m = lane_mask(seen_req.size, seen_req.addr[1:0]);
		if (seen_valid && seen_ready && seen_req.op == MEM_STORE) begin
			// wdata carries the store data on every lane
			cache_mem[seen_req.addr[9:2]] = (cache_mem[seen_req.addr[9:2]] & ~m) |
				(seen_req.wdata & m);
		end
		if (seen_valid && !seen_ready) begin
			wait_cnt = wait_cnt - 2'd1;
		end else begin
			wait_cnt = next_wait;
		end
	end

	// ---------------------------------------------------------------------------
	// reference model and output checks
	// ---------------------------------------------------------------------------
	always @(negedge clk) begin : model
		wb_t         want;
		logic [31:0] sd;
		logic [31:0] m;
		logic [1:0]  lane;
		logic        mis;
		logic        req_exp;
		if (!rst) begin
			if (u_mem_stage_top.u_mem_stage_sva.fail_cnt != 0) begin
				$display("an assertion on the L1D handshake or stall failed");
				stop_run();
			end
			if (kill_q) begin
				compare("wb.valid", wb.valid, 1'b0);
			end
			if (wb.valid) begin
				if (exp_q.size() == 0) begin
					$display("writeback seen with no instruction pending");
					stop_run();
				end else begin
					want = exp_q.pop_front();
					compare("wb.rd", wb.rd, want.rd);
					compare("wb.we", wb.we, want.we);
					compare("wb.misalign", wb.misalign, want.misalign);
					if (!want.misalign) begin
						compare("wb.value", wb.value, want.value);
					end
				end
			end
			lane = mem_in.alu_result[1:0];
			mis  = (mem_in.mem_op != MEM_NONE) && misaligned(mem_in.size, lane);
			// store data is taken in the first cycle of a request
			if (!req_pend) begin
				sd = bp_sel ? bp_data : mem_in.store_data;
			end
			m    = lane_mask(mem_in.size, lane);
			compare("haz_fwd.rd", haz_fwd.rd, mem_in.rd);
			compare("haz_fwd.we", haz_fwd.we, mem_in.valid && mem_in.we);
			compare("haz_fwd.alu_result", haz_fwd.alu_result, mem_in.alu_result);
			req_exp = mem_in.valid && (mem_in.mem_op != MEM_NONE) && !mis && !kill;
			compare("l1d_req_valid", l1d_req_valid, req_exp);
			compare("stall", stall, req_exp && !l1d_rsp.ready);
			if (req_exp) begin
				compare("l1d_req.op", l1d_req.op, mem_in.mem_op);
				compare("l1d_req.size", l1d_req.size, mem_in.size);
				compare("l1d_req.addr", l1d_req.addr, mem_in.alu_result);
				compare("l1d_req.uncached", l1d_req.uncached,
					(mem_in.alu_result & csr_nc_mask) == csr_nc_base);
				if (mem_in.mem_op == MEM_STORE) begin
					compare("l1d_req.wdata", l1d_req.wdata & m, (sd << (8 * lane)) & m);
				end
			end
			// accepted and not killed means a writeback is due
			if (mem_in.valid && !stall && !kill) begin
				want.valid    = 1'b1;
				want.rd       = mem_in.rd;
				want.we       = mem_in.we && !mis;
				want.misalign = mis;
				case (mem_in.wb_src)
					WB_MEM:  want.value = load_value(ref_mem[mem_in.alu_result[9:2]], lane,
						mem_in.ld_ext);
					WB_PC4:  want.value = mem_in.pc_4;
					WB_IMM:  want.value = mem_in.sx_imm;
					default: want.value = mem_in.alu_result;
				endcase
				if (mem_in.mem_op == MEM_STORE && !mis) begin
					ref_mem[mem_in.alu_result[9:2]] = (ref_mem[mem_in.alu_result[9:2]] & ~m) |
						((sd << (8 * lane)) & m);
				end
				exp_q.push_back(want);
			end
			req_pend = req_exp && !l1d_rsp.ready;
			kill_q   = kill;
		end
	end

	// ---------------------------------------------------------------------------
	// stimulus
	// ---------------------------------------------------------------------------
	initial begin : stimulus
		int hold;
		void'($urandom(86));
		for (int i = 0; i < 256; i++) begin
			cache_mem[i] = fill_word(i);
			ref_mem[i]   = fill_word(i);
		end
		wait_cnt    = 2'd0;
		kill_q      = 1'b0;
		req_pend    = 1'b0;
		rst         = 1'b1;
		mem_in      = '0;
		kill        = 1'b0;
		bp_sel      = 1'b0;
		bp_data     = '0;
		csr_nc_base = '0;
		csr_nc_mask = '0;
		repeat (10) @(posedge clk);
		#1;
		// window comes up with the boot map
		compare("nc_base_q", u_mem_stage_top.nc_base_q, `CORE_NC_BASE_RST);
		compare("nc_mask_q", u_mem_stage_top.nc_mask_q, `CORE_NC_MASK_RST);
		rst = 1'b0;
		for (int phase = 0; phase < N_PHASES; phase++) begin
			// new window and one idle cycle so the stage picks it up
			csr_nc_mask  = $urandom() & 32'hFFF0_0000;
			csr_nc_base  = $urandom() & csr_nc_mask;
			mem_in.valid = 1'b0;
			kill         = 1'b0;
			@(posedge clk);
			#1;
			for (int n = 0; n < N_INSTR; n++) begin
				make_instr();
				hold = 0;
				@(negedge clk);
				while (stall) begin
					hold++;
					if (hold > WAIT_LIMIT) begin
						$display("stall stayed high for more than %0d cycles", WAIT_LIMIT);
						stop_run();
					end
					@(posedge clk);
					#1;
					// bypass data from writeback keeps moving while the access waits
					bp_sel  = ($urandom_range(0, 3) == 0);
					bp_data = $urandom();
					// now and then withdraw the pending request
					if ($urandom_range(0, 7) == 0) kill = 1'b1;
					@(negedge clk);
				end
				@(posedge clk);
				#1;
			end
		end
		mem_in.valid = 1'b0;
		kill         = 1'b0;
		hold         = 0;
		while (exp_q.size() != 0 && hold < WAIT_LIMIT) begin
			@(posedge clk);
			hold++;
		end
		// one more round of checks for the last edge
		@(negedge clk);
		#1;
		if (exp_q.size() != 0) begin
			$display("%0d writebacks still missing after the drain", exp_q.size());
			stop_run();
		end else begin
			$display("TB PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire
